//--- mem_stage.f
+incdir+.
mem_stage_pkg.sv
data_memory.sv
mem_access_ctrl.sv
mem_debug_port.sv
mem_stage.sv
mem_stage_asserts.sv
tb_mem_stage.sv

//--- mem_stage_golden.txt
# kind size(0 word, 1 triple, 2 half, 3 byte) addr data rd expect, hex except rd (decimal)
# expect: writeback word, pc_source for branch (data is zero flag), word for debug; rd 0 = random
load   0 00000010 00000000 3  00000000
load   0 0000003e 00000000 0  00000000
store  0 00000000 44332211 0  00000000
load   0 00000000 00000000 4  44332211
store  3 00000001 000000aa 0  00000001
load   0 00000000 00000000 5  4433aa11
store  2 00000002 0000beef 0  00000002
load   0 00000000 00000000 6  beefaa11
store  1 00000008 ffc0ffee 0  00000008
load   0 00000008 00000000 0  00c0ffee
store  0 00000011 deadbeef 0  00000011
load   0 00000010 00000000 0  adbeef00
load   0 00000014 00000000 0  000000de
load   3 00000012 00000000 8  000000be
load   2 00000011 00000000 9  0000beef
load   1 00000011 00000000 0  00adbeef
alu    0 12345678 00000000 7  12345678
load   2 00000000 00000000 0  0000aa11
alu    0 cafef00d 00000000 0  cafef00d
load   3 00000013 00000000 0  000000ad
branch 0 00000020 00000001 0  00000001
branch 0 00000020 00000000 0  00000000
alu    0 00000000 00000000 10 00000000
store  0 0000003e 87654321 0  0000003e
debug  0 0000003e 00000000 0  87654321
debug  0 00000000 00000000 0  beef8765
debug  0 00000008 00000000 0  00c0ffee
load   0 00000000 00000000 0  beef8765
load   1 0000003f 00000000 0  00876543

//--- tb_mem_stage.sv
`include "mem_stage_consts.svh"

module tb_mem_stage
    import mem_stage_pkg::*;
();

    localparam int MAX_OPS  = 64;
    localparam int K_STORE  = 0;
    localparam int K_LOAD   = 1;
    localparam int K_ALU    = 2;
    localparam int K_BRANCH = 3;
    localparam int K_DEBUG  = 4;

    logic                      clk;
    logic                      rst;
    ex_mem_t                   ex_mem;
    mem_wb_t                   mem_wb;
    logic                      pc_source;
    logic                      dbg_req;
    logic [`MS_ADDR_WIDTH-1:0] dbg_addr;
    logic                      dbg_ack;
    mem_word_t                 dbg_data;

    int          op_kind [MAX_OPS];
    logic [1:0]  op_size [MAX_OPS];
    logic [31:0] op_addr [MAX_OPS];
    logic [31:0] op_data [MAX_OPS];
    logic [31:0] op_exp  [MAX_OPS];
    int          op_rd   [MAX_OPS];
    bit          op_fail [MAX_OPS];
    int          n_ops = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 50;
    mem_wb_t     pend_wb;               // Writeback due in the next cycle
    int          pend_idx = -1;

    mem_stage dut0 (
        .clk         (clk),
        .rst         (rst),
        .i_ex_mem    (ex_mem),
        .o_mem_wb    (mem_wb),
        .o_pc_source (pc_source),
        .i_dbg_req   (dbg_req),
        .i_dbg_addr  (dbg_addr),
        .o_dbg_ack   (dbg_ack),
        .o_dbg_data  (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic string kind_name(input int k);
        case (k)
            K_STORE:  return "store";
            K_LOAD:   return "load";
            K_ALU:    return "alu";
            K_BRANCH: return "branch";
            default:  return "debug";
        endcase
    endfunction

    function automatic int kind_code(input logic [63:0] k);
        case (k)
            "store":  return K_STORE;
            "load":   return K_LOAD;
            "alu":    return K_ALU;
            "branch": return K_BRANCH;
            "debug":  return K_DEBUG;
            default:  return -1;    // Comment or unknown line
        endcase
    endfunction

    task automatic check_wb(input int idx, input mem_wb_t got, input mem_wb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            op_fail[idx] = 1'b1;
            $display("Mismatch at %0t: o_mem_wb got rw=%b rd=%0d %h, expected rw=%b rd=%0d %h",
                     $time, got.reg_write, got.rd, got.wb_data.word,
                     exp.reg_write, exp.rd, exp.wb_data.word);
        end
    endtask

    task automatic check_word(input int idx, input string name, input mem_word_t got,
                              input mem_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            if (idx >= 0) op_fail[idx] = 1'b1;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got.word, exp.word);
        end
    endtask

    task automatic check_bit(input int idx, input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            if (idx >= 0) op_fail[idx] = 1'b1;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic read_golden();
        int              fd;
        int              n;
        int              rd;
        logic [63:0]     kind;
        logic [8*160-1:0] line;
        logic [1:0]      sz;
        logic [31:0]     addr;
        logic [31:0]     data;
        logic [31:0]     exp;
        fd = $fopen("mem_stage_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open mem_stage_golden.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %h %h %h %d %h", kind, sz, addr, data, rd, exp);
                if (n == 6 && n_ops < MAX_OPS && kind_code(kind) >= 0) begin
                    op_kind[n_ops] = kind_code(kind);
                    op_size[n_ops] = sz;
                    op_addr[n_ops] = addr;
                    op_data[n_ops] = data;
                    op_rd[n_ops]   = rd;
                    op_exp[n_ops]  = exp;
                    op_fail[n_ops] = 1'b0;
                    n_ops++;
                end
            end
            $fclose(fd);
            if (n_ops == 0) begin
                errors++;
                $display("Golden file holds no operations");
            end
        end
        limit = 10 * n_ops + 50;
    endtask

    task automatic report_op(input int idx);
        $display("op %0d %s: %s", idx, kind_name(op_kind[idx]), op_fail[idx] ? "FAIL" : "PASS");
    endtask

    // Result of the previous item is on o_mem_wb just after this edge
    task automatic finish_pending();
        if (pend_idx >= 0) begin
            check_wb(pend_idx, mem_wb, pend_wb);
            report_op(pend_idx);
            pend_idx = -1;
        end
    endtask

    task automatic run_op(input int i);
        mem_wb_t                  exp_wb;
        logic                     exp_pc;
        logic [`MS_REG_WIDTH-1:0] rd;
        rd = (op_rd[i] == 0) ? `MS_REG_WIDTH'($urandom % 31 + 1) : `MS_REG_WIDTH'(op_rd[i]);
        exp_wb.reg_write    = (op_kind[i] == K_LOAD) || (op_kind[i] == K_ALU);
        exp_wb.rd           = rd;
        exp_wb.wb_data.word = (op_kind[i] == K_BRANCH) ? op_addr[i] : op_exp[i];
        exp_pc              = (op_kind[i] == K_BRANCH) ? op_exp[i][0] : 1'b0;
        @(posedge clk);
        #1;
        finish_pending();
        ex_mem                  = '0;
        ex_mem.mem_read         = (op_kind[i] == K_LOAD);
        ex_mem.mem_write        = (op_kind[i] == K_STORE);
        ex_mem.branch           = (op_kind[i] == K_BRANCH);
        ex_mem.zero             = (op_kind[i] == K_BRANCH) ? op_data[i][0] : 1'b0;
        ex_mem.reg_write        = exp_wb.reg_write;
        ex_mem.rd               = rd;
        ex_mem.size             = mem_size_t'(op_size[i]);
        ex_mem.alu_result       = op_addr[i];
        ex_mem.store_data.word  = op_data[i];
        @(negedge clk);
        check_bit(i, "o_pc_source", pc_source, exp_pc);   // Same cycle as the input
        pend_wb  = exp_wb;
        pend_idx = i;
    endtask

    task automatic run_debug(input int i);
        @(posedge clk);
        #1;
        finish_pending();
        ex_mem   = '0;                                    // Pipeline idle during the read
        dbg_addr = op_addr[i][`MS_ADDR_WIDTH-1:0];
        dbg_req  = 1'b1;
        while (!dbg_ack) begin
            @(posedge clk);
            #1;
        end
        check_word(i, "o_dbg_data", dbg_data, op_exp[i]);
        dbg_req = 1'b0;
        while (dbg_ack) begin
            @(posedge clk);
            #1;
        end
        report_op(i);
    endtask

    initial begin
        int reset_errs;
        void'($urandom(32'h96ee));
        rst      = 1'b1;
        ex_mem   = '0;
        dbg_req  = 1'b0;
        dbg_addr = '0;
        read_golden();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_errs = errors;
        check_bit(-1, "o_dbg_ack", dbg_ack, 1'b0);
        check_bit(-1, "o_mem_wb.reg_write", mem_wb.reg_write, 1'b0);
        $display("reset state: %s", (errors == reset_errs) ? "PASS" : "FAIL");
        for (int i = 0; i < n_ops; i++) begin
            if (op_kind[i] == K_DEBUG) begin
                run_debug(i);
            end else begin
                run_op(i);
            end
        end
        @(posedge clk);
        #1;
        finish_pending();
        $display("%0d operations, %0d checks, %0d errors", n_ops, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- mem_stage_asserts.sv
module mem_stage_asserts
    import mem_stage_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input ex_mem_t  i_ex_mem,
    input mem_req_t i_mem_req,
    input logic     i_pc_source,
    input logic     i_dbg_req,
    input logic     i_dbg_ack
);

    ack_rise_with_req: assert property (@(posedge clk) disable iff (rst)
        $rose(i_dbg_ack) |-> $past(i_dbg_req))   // Ack answers a pending request
        else $error("debug ack rose while req was low");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(i_dbg_ack) |-> !$past(i_dbg_req))
        else $error("debug ack fell while req was still high");

    pc_source_rule: assert property (@(posedge clk) disable iff (rst)
        i_pc_source == (i_ex_mem.branch & i_ex_mem.zero))   // Taken branch only
        else $error("pc_source differs from branch and zero");

    req_one_direction: assert property (@(posedge clk) disable iff (rst)
        !(i_mem_req.read && i_mem_req.write))
        else $error("memory request has read and write both set");

endmodule

bind mem_stage mem_stage_asserts asrt0 (
    .clk         (clk),
    .rst         (rst),
    .i_ex_mem    (i_ex_mem),
    .i_mem_req   (mem_req),
    .i_pc_source (o_pc_source),
    .i_dbg_req   (i_dbg_req),
    .i_dbg_ack   (o_dbg_ack)
);

//--- mem_stage.sv
`include "mem_stage_consts.svh"

module mem_stage
    import mem_stage_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  ex_mem_t                   i_ex_mem,
    output mem_wb_t                   o_mem_wb,
    output logic                      o_pc_source,
    input  logic                      i_dbg_req,
    input  logic [`MS_ADDR_WIDTH-1:0] i_dbg_addr,
    output logic                      o_dbg_ack,
    output mem_word_t                 o_dbg_data
);

    mem_req_t                   mem_req;
    mem_word_t                  mem_rdata;
    logic [`MS_ADDR_WIDTH-1:0]  dbg_mem_addr;
    mem_word_t                  dbg_mem_data;

    mem_access_ctrl ctrl0 (
        .clk         (clk),
        .rst         (rst),
        .i_ex_mem    (i_ex_mem),
        .o_mem_req   (mem_req),
        .i_rdata     (mem_rdata),
        .o_mem_wb    (o_mem_wb),
        .o_pc_source (o_pc_source)
    );

    data_memory mem0 (
        .clk         (clk),
        .rst         (rst),
        .i_req       (mem_req),
        .o_rdata     (mem_rdata),
        .i_dbg_addr  (dbg_mem_addr),
        .o_dbg_rdata (dbg_mem_data)
    );

    mem_debug_port dbg0 (
        .clk        (clk),
        .rst        (rst),
        .i_req      (i_dbg_req),
        .i_addr     (i_dbg_addr),
        .o_ack      (o_dbg_ack),
        .o_data     (o_dbg_data),
        .o_mem_addr (dbg_mem_addr),
        .i_mem_data (dbg_mem_data)
    );

endmodule

//--- mem_debug_port.sv
`include "mem_stage_consts.svh"

module mem_debug_port
    import mem_stage_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_req,
    input  logic [`MS_ADDR_WIDTH-1:0] i_addr,
    output logic                      o_ack,
    output mem_word_t                 o_data,
    output logic [`MS_ADDR_WIDTH-1:0] o_mem_addr,
    input  mem_word_t                 i_mem_data
);

    dbg_state_t                 state;
    logic                       ack_q;
    logic [`MS_ADDR_WIDTH-1:0]  addr_q;
    mem_word_t                  data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DBG_IDLE;
            ack_q <= 1'b0;
        end else begin
            case (state)
                DBG_IDLE: begin
                    if (i_req) state <= DBG_FETCH;
                end
                DBG_FETCH: state <= DBG_HOLD;   // Memory samples addr_q here
                DBG_HOLD: begin
                    if (!ack_q) begin
                        ack_q <= 1'b1;           // Word is captured with ack
                    end else if (!i_req) begin
                        state <= DBG_RELEASE;
                    end
                end
                DBG_RELEASE: begin
                    ack_q <= 1'b0;
                    state <= DBG_IDLE;
                end
                default: state <= DBG_IDLE;
            endcase
        end
    end

    // Latched debug address and captured word
    always_ff @(posedge clk) begin
        if (state == DBG_IDLE && i_req) addr_q <= i_addr;
        if (state == DBG_HOLD && !ack_q) data_q <= i_mem_data;   // Steady while ack is high
    end

    assign o_mem_addr = addr_q;
    assign o_ack      = ack_q;
    assign o_data     = data_q;

endmodule

//--- mem_access_ctrl.sv
`include "mem_stage_consts.svh"

module mem_access_ctrl
    import mem_stage_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  ex_mem_t   i_ex_mem,
    output mem_req_t  o_mem_req,
    input  mem_word_t i_rdata,
    output mem_wb_t   o_mem_wb,
    output logic      o_pc_source
);

    logic                      reg_write_q;
    logic                      load_q;      // Writeback takes memory data
    logic [`MS_REG_WIDTH-1:0]  rd_q;
    mem_word_t                 alu_q;

    // Memory request straight from the pipeline register
    always_comb begin
        o_mem_req.read  = i_ex_mem.mem_read;
        o_mem_req.write = i_ex_mem.mem_write;
        o_mem_req.size  = i_ex_mem.size;
        o_mem_req.addr  = i_ex_mem.alu_result[`MS_ADDR_WIDTH-1:0];
        o_mem_req.wdata = i_ex_mem.store_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_q <= 1'b0;
            load_q      <= 1'b0;
        end else begin
            reg_write_q <= i_ex_mem.reg_write;
            load_q      <= o_mem_req.read;
        end
    end

    always_ff @(posedge clk) begin
        rd_q       <= i_ex_mem.rd;
        alu_q.word <= i_ex_mem.alu_result;
    end

    // Memory data arrives in the same cycle as the registered fields
    always_comb begin
        o_mem_wb.reg_write = reg_write_q;
        o_mem_wb.rd        = rd_q;
        o_mem_wb.wb_data   = load_q ? i_rdata : alu_q;
    end

    assign o_pc_source = i_ex_mem.branch & i_ex_mem.zero;   // Taken branch

endmodule

//--- data_memory.sv
`include "mem_stage_consts.svh"

module data_memory
    import mem_stage_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  mem_req_t                  i_req,
    output mem_word_t                 o_rdata,
    input  logic [`MS_ADDR_WIDTH-1:0] i_dbg_addr,
    output mem_word_t                 o_dbg_rdata
);

    localparam int AW    = `MS_ADDR_WIDTH;
    localparam int LANES = `MS_DATA_WIDTH / 8;

    logic [7:0] mem [`MS_MEM_BYTES];   // Byte array
    mem_word_t  rdata_q;               // Load result
    mem_word_t  dbg_q;                 // Debug word

    // Address of a lane, wraps at the top of memory
    function automatic logic [AW-1:0] lane_addr(input logic [AW-1:0] base, input int lane);
        return base + AW'(lane);
    endfunction

    // Word uses all lanes, byte only lane 0
    function automatic logic lane_en(input mem_size_t size, input int lane);
        return (lane + int'(size)) < LANES;
    endfunction

    // Store port, lands on the edge that ends the request cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MS_MEM_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (i_req.write) begin
            for (int k = 0; k < LANES; k++) begin
                if (lane_en(i_req.size, k)) begin
                    mem[lane_addr(i_req.addr, k)] <= i_req.wdata.lanes[k];
                end
            end
        end
    end

    // Load port, upper lanes zeroed for short accesses
    always_ff @(posedge clk) begin
        if (i_req.read) begin
            for (int k = 0; k < LANES; k++) begin
                rdata_q.lanes[k] <= lane_en(i_req.size, k) ?
                                    mem[lane_addr(i_req.addr, k)] : 8'h00;
            end
        end
    end

    // Debug port reads a full word every cycle
    // A store in the same cycle is not yet visible here
    always_ff @(posedge clk) begin
        for (int k = 0; k < LANES; k++) begin
            dbg_q.lanes[k] <= mem[lane_addr(i_dbg_addr, k)];
        end
    end

    assign o_rdata     = rdata_q;
    assign o_dbg_rdata = dbg_q;

endmodule

//--- mem_stage_pkg.sv
`include "mem_stage_consts.svh"

package mem_stage_pkg;

    // Same order as the two mask bits {mask_1, mask_2}
    typedef enum logic [1:0] {
        SZ_WORD   = 2'b00,   // 4 bytes
        SZ_TRIPLE = 2'b01,   // 3 bytes
        SZ_HALF   = 2'b10,   // 2 bytes
        SZ_BYTE   = 2'b11    // 1 byte
    } mem_size_t;

    // Lane 0 is the byte at the lowest address (little endian)
    typedef union packed {
        logic [`MS_DATA_WIDTH-1:0]          word;
        logic [`MS_DATA_WIDTH/8-1:0][7:0]   lanes;
    } mem_word_t;

    typedef struct packed {
        logic                       mem_read;
        logic                       mem_write;
        logic                       branch;
        logic                       zero;        // ALU zero flag
        logic                       reg_write;
        logic [`MS_REG_WIDTH-1:0]   rd;
        mem_size_t                  size;
        logic [`MS_DATA_WIDTH-1:0]  alu_result;  // Low bits are the byte address
        mem_word_t                  store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                       read;
        logic                       write;
        mem_size_t                  size;
        logic [`MS_ADDR_WIDTH-1:0]  addr;
        mem_word_t                  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                       reg_write;
        logic [`MS_REG_WIDTH-1:0]   rd;
        mem_word_t                  wb_data;
    } mem_wb_t;

    typedef enum logic [1:0] {
        DBG_IDLE,
        DBG_FETCH,
        DBG_HOLD,
        DBG_RELEASE
    } dbg_state_t;

endpackage

//--- mem_stage_consts.svh
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// Data path word width
`define MS_DATA_WIDTH 32

// Data memory size in bytes, addresses wrap modulo this size
`define MS_MEM_BYTES 64

// Byte address width, log2 of the memory size
`define MS_ADDR_WIDTH 6

// Destination register index width
`define MS_REG_WIDTH 5

`endif
